//--- tb/classifier_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// classifier_tb: table-driven testbench of the classifier slice.
// Holds the step table, a reference model of the MAC table, the PIO
// and packet drivers, the compare tasks and the cycle limit.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module classifier_tb;
	import pio_pkg::*;
	import classifier_pkg::*;

	typedef enum {ST_WR, ST_RD, ST_PKT, ST_IDLE} step_kind_t;

	typedef struct {
		step_kind_t kind;
		pio_word_t  addr;
		pio_word_t  data;
		pio_word_t  exp;         // expected read data.
		bit         exp_rvalid;  // the read must return data.
		bit         from_model;  // expected count comes from the model.
		mac_addr_t  src;
		mac_addr_t  dst;
		port_id_t   port;
		int         pulses;      // idle length in clk_div pulses.
		bit         age_all;     // the idle is long enough to age everything.
	} step_t;

	logic clk = 1'b0;
	logic arst_n, clk_div, reg_bs, reg_rd, reg_wr, pkt_valid;
	pio_word_t reg_addr, reg_din, pio_rdata;
	mac_addr_t src_mac, dst_mac;
	port_id_t src_port, res_port;
	logic pio_ack, pio_rvalid, res_valid, res_flood;

	step_t steps[$];
	int seed = 32'hce0a_b317;
	int cycles = 0;
	int cycle_limit = 100;     // raised once the table is built.
	logic exp_v[2];            // expected results in flight, index 1 is due next.
	logic exp_flood[2];
	port_id_t exp_port[2];
	logic m_valid[16];         // reference copy of the forwarding table.
	mac_addr_t m_mac[16];
	port_id_t m_port[16];
	mac_addr_t mac_a, mac_u, mac_b, mac_m, mac_m2, mac_n, mac_x, mac_y, mac_z;

	classifier_top classifier_top_inst (
		.clk(clk), .arst_n(arst_n), .clk_div(clk_div),
		.reg_bs(reg_bs), .reg_rd(reg_rd), .reg_wr(reg_wr),
		.reg_addr(reg_addr), .reg_din(reg_din),
		.pio_ack(pio_ack), .pio_rvalid(pio_rvalid), .pio_rdata(pio_rdata),
		.pkt_valid(pkt_valid), .src_mac(src_mac), .dst_mac(dst_mac), .src_port(src_port),
		.res_valid(res_valid), .res_flood(res_flood), .res_port(res_port)
	);

	always #5 clk = ~clk;  // 10 unit period.

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input pio_word_t got, input pio_word_t exp);
		if (got !== exp)
			stop_with_error($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_port(input string name, input port_id_t got, input port_id_t exp);
		if (got !== exp)
			stop_with_error($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_with_error($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	// xor of the twelve nibbles, which is already the 16-entry index.
	function automatic logic [3:0] fold_nibbles(input mac_addr_t mac);
		logic [3:0] x;
		x = 4'h0;
		for (int i = 0; i < 12; i++)
			x = x ^ mac[i*4 +: 4];
		return x;
	endfunction

	function automatic pio_word_t model_count();
		pio_word_t n;
		n = 0;
		for (int i = 0; i < 16; i++)
			n = n + m_valid[i];
		return n;
	endfunction

	function automatic mac_addr_t rand_mac();
		mac_addr_t m;
		m[47:32] = $random(seed);
		m[31:0] = $random(seed);
		return m;
	endfunction

	function automatic step_t new_step(input step_kind_t kind);
		step_t s;
		s.kind = kind;
		s.addr = 0;
		s.data = 0;
		s.exp = 0;
		s.exp_rvalid = 0;
		s.from_model = 0;
		s.src = 0;
		s.dst = 0;
		s.port = 0;
		s.pulses = 0;
		s.age_all = 0;
		return s;
	endfunction

	function automatic void add_wr(input pio_word_t addr, input pio_word_t data);
		step_t s;
		s = new_step(ST_WR);
		s.addr = addr;
		s.data = data;
		steps.push_back(s);
	endfunction

	function automatic void add_rd(input pio_word_t addr, input pio_word_t exp,
			input bit rv, input bit from_model);
		step_t s;
		s = new_step(ST_RD);
		s.addr = addr;
		s.exp = exp;
		s.exp_rvalid = rv;
		s.from_model = from_model;
		steps.push_back(s);
	endfunction

	function automatic void add_pkt(input mac_addr_t src, input mac_addr_t dst,
			input port_id_t port);
		step_t s;
		s = new_step(ST_PKT);
		s.src = src;
		s.dst = dst;
		s.port = port;
		steps.push_back(s);
	endfunction

	function automatic void add_idle(input int pulses, input bit age_all);
		step_t s;
		s = new_step(ST_IDLE);
		s.pulses = pulses;
		s.age_all = age_all;
		steps.push_back(s);
	endfunction

	// one falling edge: new clk_div, then the packet result that is due now.
	task automatic step_clock();
		@(negedge clk);
		cycles++;
		if (cycles > cycle_limit)
			stop_with_error($sformatf("The run passed its limit of %0d cycles.", cycle_limit));
		clk_div = (cycles % 4 == 0);
		check_flag("res_valid", res_valid, exp_v[1]);
		if (exp_v[1]) begin
			check_flag("res_flood", res_flood, exp_flood[1]);
			check_port("res_port", res_port, exp_port[1]);
		end
		exp_v[1] = exp_v[0];
		exp_flood[1] = exp_flood[0];
		exp_port[1] = exp_port[0];
		exp_v[0] = 1'b0;
	endtask

	task automatic do_pio(input step_t s);
		int waited;
		reg_bs = 1'b1;
		reg_rd = (s.kind == ST_RD);
		reg_wr = (s.kind == ST_WR);
		reg_addr = s.addr;
		reg_din = s.data;
		if (s.from_model)
			s.exp = model_count();  // earlier learns are committed by the ack.
		step_clock();
		reg_bs = 1'b0;
		reg_rd = 1'b0;
		reg_wr = 1'b0;
		waited = 0;
		while (!pio_ack) begin
			if (waited == 16)
				stop_with_error("No pio_ack came back within 16 cycles of a request.");
			step_clock();
			waited++;
		end
		if (s.exp_rvalid) begin
			if (!pio_rvalid)
				stop_with_error($sformatf("A read of address 0x%h gave no pio_rvalid.", s.addr));
			check_word("pio_rdata", pio_rdata, s.exp);
		end else begin
			check_flag("pio_rvalid", pio_rvalid, 1'b0);
		end
		waited = 0;
		while (pio_ack) begin
			if (waited == 16)
				stop_with_error("pio_ack stayed high for more than 16 cycles.");
			step_clock();
			waited++;
		end
	endtask

	// the model looks up dst first and then learns src, as the DUT does.
	task automatic do_packet(input step_t s);
		logic [3:0] di;
		logic [3:0] si;
		di = fold_nibbles(s.dst);
		si = fold_nibbles(s.src);
		pkt_valid = 1'b1;
		src_mac = s.src;
		dst_mac = s.dst;
		src_port = s.port;
		exp_v[0] = 1'b1;
		exp_flood[0] = !(m_valid[di] && m_mac[di] == s.dst);
		exp_port[0] = exp_flood[0] ? 3'd0 : m_port[di];
		m_valid[si] = 1'b1;
		m_mac[si] = s.src;
		m_port[si] = s.port;
		step_clock();
		pkt_valid = 1'b0;
	endtask

	task automatic do_idle(input step_t s);
		int seen;
		seen = 0;
		while (seen < s.pulses) begin
			step_clock();
			if (clk_div)
				seen++;
		end
		if (s.age_all) begin
			for (int i = 0; i < 16; i++)
				m_valid[i] = 1'b0;
		end
	endtask

	initial begin
		arst_n = 1'b0;
		clk_div = 1'b0;
		reg_bs = 1'b0;
		reg_rd = 1'b0;
		reg_wr = 1'b0;
		reg_addr = '0;
		reg_din = '0;
		pkt_valid = 1'b0;
		src_mac = '0;
		dst_mac = '0;
		src_port = '0;
		exp_v[0] = 1'b0;
		exp_v[1] = 1'b0;
		for (int i = 0; i < 16; i++)
			m_valid[i] = 1'b0;
		mac_a = rand_mac();
		mac_u = rand_mac();
		mac_b = rand_mac();
		mac_m = rand_mac();
		mac_m2 = mac_m ^ 48'h0000_0000_0011;  // same nibble xor, other MAC.
		mac_n = rand_mac();
		mac_x = rand_mac();
		mac_y = rand_mac();
		mac_z = rand_mac();

		add_rd(REG_AGING_TIME, 32'h0000_0fff, 1, 0);  // reset values.
		add_rd(REG_ENTRY_COUNT, 0, 1, 1);
		add_wr(REG_AGING_TIME, 32'habcd_e123);        // register access.
		add_rd(REG_AGING_TIME, 32'h0000_0123, 1, 0);
		add_rd(32'h8, 0, 0, 0);
		add_wr(REG_ENTRY_COUNT, 32'h1f);
		add_rd(REG_ENTRY_COUNT, 0, 1, 1);
		add_pkt(mac_a, mac_u, 3'd1);                  // flood, learn, hit.
		add_rd(REG_ENTRY_COUNT, 0, 1, 1);
		add_pkt(mac_u, mac_b, 3'd5);
		add_rd(REG_ENTRY_COUNT, 0, 1, 1);
		add_pkt(mac_b, mac_u, 3'd2);
		add_pkt(mac_m, mac_n, 3'd3);                  // back to back, forwarding.
		add_pkt(mac_n, mac_m, 3'd4);
		add_rd(REG_ENTRY_COUNT, 0, 1, 1);
		add_pkt(mac_m2, mac_n, 3'd6);                 // collision replaces mac_m.
		add_pkt(mac_n, mac_m, 3'd4);
		add_pkt(mac_n, mac_m2, 3'd4);
		add_rd(REG_ENTRY_COUNT, 0, 1, 1);
		add_wr(REG_AGING_TIME, 32'h3);                // aging.
		add_pkt(mac_x, mac_y, 3'd1);
		add_pkt(mac_y, mac_x, 3'd2);
		add_idle(8, 1);
		add_rd(REG_ENTRY_COUNT, 0, 1, 1);
		add_pkt(mac_z, mac_x, 3'd7);
		for (int i = 0; i < 4; i++) begin
			add_idle(2, 0);
			add_pkt(mac_z, mac_z, 3'd7);
		end
		add_rd(REG_ENTRY_COUNT, 0, 1, 1);

		cycle_limit = 10;
		foreach (steps[i]) begin
			case (steps[i].kind)
				ST_PKT: cycle_limit += 2 * 1;
				ST_IDLE: cycle_limit += 2 * (steps[i].pulses * 4 + 4);
				default: cycle_limit += 2 * 34;
			endcase
		end

		repeat (3) step_clock();
		arst_n = 1'b1;
		foreach (steps[i]) begin
			case (steps[i].kind)
				ST_PKT: do_packet(steps[i]);
				ST_IDLE: do_idle(steps[i]);
				default: do_pio(steps[i]);
			endcase
		end
		repeat (3) step_clock();  // drain the result pipeline.
		$display("Done: no errors");
		$finish;
	end

endmodule

//--- verilog.f
verilog/pio_pkg.sv
verilog/classifier_pkg.sv
verilog/classifier_reg.sv
verilog/aging_timer.sv
verilog/mac_table.sv
verilog/classifier_top.sv
tb/classifier_tb.sv

//--- verilog/aging_timer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// aging_timer: aging period counter.
// Counts clk_div enables and gives one age_tick per aging_time.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module aging_timer (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        clk_div,     // one count per enable.
	input  classifier_pkg::aging_time_t aging_time,  // period length in enables.
	output logic                        age_tick
);
	import classifier_pkg::*;

	aging_time_t cnt;       // enables seen in the running period.
	aging_time_t cnt_inc;
	logic        period_done;

	// cnt never goes past aging_time - 1 in steady state, so the increment
	// cannot wrap even with the longest period.
	assign cnt_inc = cnt + 1'b1;

	// a greater-or-equal test rather than equality.
	// When software shortens the period below the running count, the period
	// ends at the next enable instead of after a full counter wrap.
	assign period_done = (cnt_inc >= aging_time);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
			age_tick <= 1'b0;
		end else begin
			age_tick <= clk_div & period_done;  // one clk wide pulse.
			if (clk_div) begin
				if (period_done)
					cnt <= '0;  // restart the next period.
				else
					cnt <= cnt_inc;
			end
		end
	end

endmodule

//--- verilog/classifier_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types of the layer-2 classifier datapath.
// MAC address, switch port, aging period and table entry count,
// plus the default table depth and the aging reset value.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package classifier_pkg;

	localparam int MAC_W = 48;        // an Ethernet MAC address.
	localparam int PORT_W = 3;        // up to eight switch ports.
	localparam int AGING_W = 12;      // aging period in clk_div enables.
	localparam int ENTRY_CNT_W = 5;   // holds 0 to 16 valid entries.

	typedef logic [MAC_W-1:0] mac_addr_t;
	typedef logic [PORT_W-1:0] port_id_t;
	typedef logic [AGING_W-1:0] aging_time_t;
	typedef logic [ENTRY_CNT_W-1:0] entry_count_t;

	// default number of table entries.
	// The entry counter above is sized for this depth.
	localparam int DEF_TABLE_DEPTH = 16;

	// out of reset the aging period is the longest one the register holds.
	localparam aging_time_t AGING_TIME_RESET = '1;

endpackage

//--- verilog/classifier_reg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// classifier_reg: PIO register bank of the classifier.
// Holds the aging_time register, returns the table entry count,
// and paces pio_ack / pio_rvalid on the clk_div enable.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module classifier_reg (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic                         clk_div,      // bus pacing enable.
	input  logic                         reg_bs,
	input  logic                         reg_rd,
	input  logic                         reg_wr,
	input  pio_pkg::pio_word_t           reg_addr,
	input  pio_pkg::pio_word_t           reg_din,
	input  classifier_pkg::entry_count_t entry_count,
	output logic                         pio_ack,
	output logic                         pio_rvalid,
	output pio_pkg::pio_word_t           pio_rdata,
	output classifier_pkg::aging_time_t  aging_time
);
	import pio_pkg::*;
	import classifier_pkg::*;

	reg_offset_t offset;     // register select taken from the address.
	logic        rd_hit;     // the offset names a readable register.
	logic        sel_aging;  // the offset names the aging_time register.
	logic        wr_aging;
	logic        ack_pend;   // a request waits for its acknowledge.
	logic        rd_d1;      // the pending request is a read.
	logic        ack_fire;

	assign offset = reg_addr[REG_OFFSET_W-1:0];
	assign wr_aging = reg_bs & reg_wr & sel_aging;  // writes land on the next edge.
	assign ack_fire = clk_div & ack_pend;           // the edge that issues the ack.

	// address decode and read mux.
	// The testbench holds reg_addr until pio_ack, so the mux output is
	// still valid when pio_rvalid comes up.
	always_comb begin
		rd_hit = 1'b0;
		sel_aging = 1'b0;
		pio_rdata = '0;
		case (offset)
			REG_AGING_TIME: begin
				rd_hit = 1'b1;
				sel_aging = 1'b1;
				pio_rdata = pio_word_t'(aging_time);
			end
			REG_ENTRY_COUNT: begin
				rd_hit = 1'b1;   // writes here have no select and fall away.
				pio_rdata = pio_word_t'(entry_count);
			end
			default: rd_hit = 1'b0;  // undecoded, acked but no read data.
		endcase
	end

	// a new request wins over the clk_div clear, so a request made in a
	// clk_div cycle is still acknowledged on the next enable.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ack_pend <= 1'b0;
			rd_d1 <= 1'b0;
		end else begin
			if (reg_bs && (reg_rd || reg_wr))
				ack_pend <= 1'b1;
			else if (clk_div)
				ack_pend <= 1'b0;

			if (reg_rd)
				rd_d1 <= reg_bs;  // a read to another bank drops the flag.
			else if (ack_fire)
				rd_d1 <= 1'b0;    // the read window closes with the ack.
		end
	end

	// ack and rvalid move only on clk_div edges.
	// Each is high for exactly one enable period.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pio_ack <= 1'b0;
			pio_rvalid <= 1'b0;
			aging_time <= AGING_TIME_RESET;
		end else begin
			if (clk_div) begin
				pio_ack <= ack_pend;
				pio_rvalid <= ack_pend & rd_d1 & rd_hit;
			end
			if (wr_aging)
				aging_time <= reg_din[AGING_W-1:0];  // upper data bits are dropped.
		end
	end

endmodule

//--- verilog/classifier_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// classifier_top: classifier slice of the layer-2 switch.
// Connects the PIO register bank, the aging timer and the MAC table.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module classifier_top #(
	parameter int TABLE_DEPTH = classifier_pkg::DEF_TABLE_DEPTH
) (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      clk_div,
	input  logic                      reg_bs,
	input  logic                      reg_rd,
	input  logic                      reg_wr,
	input  pio_pkg::pio_word_t        reg_addr,
	input  pio_pkg::pio_word_t        reg_din,
	output logic                      pio_ack,
	output logic                      pio_rvalid,
	output pio_pkg::pio_word_t        pio_rdata,
	input  logic                      pkt_valid,
	input  classifier_pkg::mac_addr_t src_mac,
	input  classifier_pkg::mac_addr_t dst_mac,
	input  classifier_pkg::port_id_t  src_port,
	output logic                      res_valid,
	output logic                      res_flood,
	output classifier_pkg::port_id_t  res_port
);
	import classifier_pkg::*;

	aging_time_t  aging_time;   // from the register bank to the timer.
	logic         age_tick;     // starts one aging sweep.
	entry_count_t entry_count;  // table occupancy, read back over PIO.

	classifier_reg classifier_reg_inst (
		.clk         (clk),
		.arst_n      (arst_n),
		.clk_div     (clk_div),
		.reg_bs      (reg_bs),
		.reg_rd      (reg_rd),
		.reg_wr      (reg_wr),
		.reg_addr    (reg_addr),
		.reg_din     (reg_din),
		.entry_count (entry_count),
		.pio_ack     (pio_ack),
		.pio_rvalid  (pio_rvalid),
		.pio_rdata   (pio_rdata),
		.aging_time  (aging_time)
	);

	aging_timer aging_timer_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.clk_div    (clk_div),
		.aging_time (aging_time),
		.age_tick   (age_tick)
	);

	mac_table #(
		.TABLE_DEPTH (TABLE_DEPTH)
	) mac_table_inst (
		.clk         (clk),
		.arst_n      (arst_n),
		.pkt_valid   (pkt_valid),
		.src_mac     (src_mac),
		.dst_mac     (dst_mac),
		.src_port    (src_port),
		.age_tick    (age_tick),
		.res_valid   (res_valid),
		.res_flood   (res_flood),
		.res_port    (res_port),
		.entry_count (entry_count)
	);

endmodule

//--- verilog/mac_table.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mac_table: direct-mapped MAC forwarding table.
// Two-stage pipeline with the dst lookup in stage 1 and the src learn
// in stage 2, forwarding between them, an aging sweep on age_tick and
// a running count of valid entries.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mac_table #(
	parameter int TABLE_DEPTH = classifier_pkg::DEF_TABLE_DEPTH
) (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic                         pkt_valid,   // one strobe per packet.
	input  classifier_pkg::mac_addr_t    src_mac,
	input  classifier_pkg::mac_addr_t    dst_mac,
	input  classifier_pkg::port_id_t     src_port,
	input  logic                         age_tick,
	output logic                         res_valid,   // two cycles after pkt_valid.
	output logic                         res_flood,
	output classifier_pkg::port_id_t     res_port,
	output classifier_pkg::entry_count_t entry_count
);
	import classifier_pkg::*;

	localparam int IDX_W = (TABLE_DEPTH > 1) ? $clog2(TABLE_DEPTH) : 1;

	typedef logic [IDX_W-1:0] idx_t;

	// folds the twelve nibbles of a MAC together.
	// The 4-bit result is then cut or widened to the index width.
	function automatic idx_t mac_hash(input mac_addr_t mac);
		logic [3:0] x;
		x = '0;
		for (int i = 0; i < MAC_W / 4; i++) begin
			x = x ^ mac[i*4 +: 4];
		end
		return idx_t'(x);
	endfunction

	mac_addr_t mac_mem [TABLE_DEPTH];   // learned MAC per slot.
	port_id_t  port_mem [TABLE_DEPTH];  // port the MAC was seen on.

	logic [TABLE_DEPTH-1:0] valid;      // the slot holds a live entry.
	logic [TABLE_DEPTH-1:0] active;     // learned since the last tick.
	logic [TABLE_DEPTH-1:0] valid_nxt;
	logic [TABLE_DEPTH-1:0] active_nxt;

	logic      s1_valid;
	idx_t      s1_src_idx;
	idx_t      s1_dst_idx;
	mac_addr_t s1_src_mac;
	mac_addr_t s1_dst_mac;
	port_id_t  s1_src_port;

	idx_t      s2_src_idx;   // learn target, valid while res_valid is high.
	mac_addr_t s2_src_mac;
	port_id_t  s2_src_port;

	logic         fwd;       // stage 2 writes the slot that stage 1 reads.
	logic         ent_valid;
	mac_addr_t    ent_mac;
	port_id_t     ent_port;
	logic         hit;
	logic         add;       // the learn fills an empty slot.
	entry_count_t rm_cnt;    // entries dropped in this edge.
	entry_count_t count_nxt;

	// the stage 2 write only reaches the memory at the end of its cycle, so
	// a lookup one packet behind takes the entry straight from stage 2.
	assign fwd = res_valid && (s2_src_idx == s1_dst_idx);
	assign ent_valid = fwd | valid[s1_dst_idx];
	assign ent_mac = fwd ? s2_src_mac : mac_mem[s1_dst_idx];
	assign ent_port = fwd ? s2_src_port : port_mem[s1_dst_idx];
	assign hit = ent_valid && (ent_mac == s1_dst_mac);

	// aging sweep first, then the learn on top of it.
	// A learn that meets a tick on the same slot keeps the entry alive.
	always_comb begin
		valid_nxt = valid;
		active_nxt = active;
		rm_cnt = '0;
		if (age_tick) begin
			valid_nxt = valid & active;  // idle entries go.
			active_nxt = '0;             // the rest must be learned again.
		end
		if (res_valid) begin
			valid_nxt[s2_src_idx] = 1'b1;
			active_nxt[s2_src_idx] = 1'b1;
		end
		for (int i = 0; i < TABLE_DEPTH; i++) begin
			if (valid[i] && !valid_nxt[i])
				rm_cnt = rm_cnt + 1'b1;
		end
	end

	// a learn over another MAC in a live slot leaves the count alone.
	assign add = res_valid & ~valid[s2_src_idx];
	assign count_nxt = entry_count + entry_count_t'(add) - rm_cnt;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			s1_valid <= 1'b0;
			res_valid <= 1'b0;
			valid <= '0;
			active <= '0;
			entry_count <= '0;
		end else begin
			s1_valid <= pkt_valid;
			res_valid <= s1_valid;
			valid <= valid_nxt;
			active <= active_nxt;
			entry_count <= count_nxt;
		end
	end

	// pipeline payload and table contents.
	// The valid flags above say when these hold anything.
	always_ff @(posedge clk) begin
		if (pkt_valid) begin
			s1_src_idx <= mac_hash(src_mac);
			s1_dst_idx <= mac_hash(dst_mac);
			s1_src_mac <= src_mac;
			s1_dst_mac <= dst_mac;
			s1_src_port <= src_port;
		end
		if (s1_valid) begin
			res_flood <= ~hit;
			res_port <= hit ? ent_port : '0;  // port 0 on a flood.
			s2_src_idx <= s1_src_idx;
			s2_src_mac <= s1_src_mac;
			s2_src_port <= s1_src_port;
		end
		if (res_valid) begin
			mac_mem[s2_src_idx] <= s2_src_mac;   // replaces any MAC in the slot.
			port_mem[s2_src_idx] <= s2_src_port;
		end
	end

endmodule

//--- verilog/pio_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PIO bus definitions for the classifier register bank.
// Holds the bus word type, the width of the register-select field
// and the offsets of the registers that the bank decodes.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package pio_pkg;

	localparam int PIO_W = 32;        // width of one PIO address or data word.
	localparam int REG_OFFSET_W = 4;  // low address bits that pick a register.

	typedef logic [PIO_W-1:0] pio_word_t;

	// the bank select already qualifies the upper address bits, so only the
	// low nibble of reg_addr is looked at inside the bank.
	typedef logic [REG_OFFSET_W-1:0] reg_offset_t;

	// register map of the classifier bank.
	localparam reg_offset_t REG_AGING_TIME = 4'h0;   // read/write.
	localparam reg_offset_t REG_ENTRY_COUNT = 4'h4;  // read only.

endpackage
